// ==== run_sim.sh ====
#!/bin/sh
# Build the tx_code testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tx_code

verilator --binary --timing --assert \
  --top-module tb_tx_code \
  -f tx_code.f \
  -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

// ==== src/code_group_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_group_lookup
  import tx_code_pkg::*;
(
  input  wire logic [SYM_W-1:0]   sym_kind,
  input  wire logic [3:0]         data_x,
  input  wire logic               running_disparity,
  input  wire logic [GROUP_W-1:0] tx_code_group,
  output logic      [GROUP_W-1:0] next_group
);

  logic [GROUP_W-1:0] data_neg;
  logic [GROUP_W-1:0] data_pos;
  logic               data_in_range;

  assign data_in_range = (32'(data_x) <= DATA_MAX_X);

  // Both columns read out, disparity picks one below
  always_comb begin
    if (data_in_range) begin
      data_neg = DATA_NEG_TABLE[data_x];
      data_pos = DATA_POS_TABLE[data_x];
    end else begin
      data_neg = tx_code_group;
      data_pos = tx_code_group;
    end
  end

  always_comb begin
    case (sym_kind)
      SYM_DATA: begin
        next_group = running_disparity ? data_pos : data_neg;
      end
      SYM_K28_5: begin
        next_group = running_disparity ? K28_5_POS : K28_5_NEG;
      end
      SYM_K27_7: begin
        next_group = running_disparity ? K27_7_POS : K27_7_NEG;
      end
      SYM_K23_7: begin
        next_group = running_disparity ? K23_7_POS : K23_7_NEG;
      end
      SYM_K29_7: begin
        next_group = running_disparity ? K29_7_POS : K29_7_NEG;
      end
      SYM_D5_6: begin
        next_group = D5_6_GROUP;  // Same in either column
      end
      default: begin
        next_group = tx_code_group;  // Unknown octet repeats last group
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/code_group_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_group_register
  import tx_code_pkg::*;
#(
  parameter bit INIT_DISPARITY = 1'b0
) (
  input  wire logic               clock,
  input  wire logic               rst,
  input  wire logic [SYM_W-1:0]   sym_kind,
  input  wire logic [GROUP_W-1:0] next_group,
  output logic      [GROUP_W-1:0] tx_code_group,
  output logic                    tx_even,
  output logic                    running_disparity
);

  logic [3:0] next_ones;
  logic       next_disparity;
  logic       next_even;
  logic       group_seen;  // A real group has left the register

  function automatic logic [3:0] count_ones(input logic [GROUP_W-1:0] group);
    logic [3:0] total;
    total = 4'd0;
    for (int i = 0; i < GROUP_W; i++) begin
      total = total + {3'b000, group[i]};
    end
    return total;
  endfunction

  assign next_ones = count_ones(next_group);

  // Unbalanced groups set the new disparity, balanced ones keep it
  always_comb begin
    next_disparity = running_disparity;
    if (sym_kind != SYM_NONE) begin
      if (next_ones == 4'd6) begin
        next_disparity = 1'b1;
      end else if (next_ones == 4'd4) begin
        next_disparity = 1'b0;
      end
    end
  end

  always_comb begin
    case (sym_kind)
      SYM_K28_5: next_even = 1'b1;
      SYM_D5_6:  next_even = 1'b0;
      default:   next_even = ~tx_even;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      tx_code_group     <= '0;
      tx_even           <= 1'b0;
      running_disparity <= INIT_DISPARITY;
      group_seen        <= 1'b0;
    end else begin
      tx_code_group     <= next_group;
      tx_even           <= next_even;
      running_disparity <= next_disparity;
      group_seen        <= group_seen | (sym_kind != SYM_NONE);
    end
  end

  // Only valid 8b/10b weights reach the line
  group_weight_a : assert property (
    @(posedge clock) disable iff (rst)
    group_seen |-> (count_ones(tx_code_group) inside {4'd4, 4'd5, 4'd6})
  );

endmodule

`default_nettype wire

// ==== src/ordered_set_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ordered_set_decode
  import tx_code_pkg::*;
(
  input  wire logic               clock,
  input  wire logic               rst,
  input  wire logic [OCTET_W-1:0] tx_o_set,
  output logic      [SYM_W-1:0]   sym_kind,
  output logic      [3:0]         data_x
);

  octet_u octet;
  logic   idle_pending;  // Second half of /I/ still owed
  logic   data_ok;

  assign octet = tx_o_set;

  assign data_x  = octet.f.x[3:0];
  assign data_ok = (octet.f.y == 3'd0) && (32'(octet.f.x) <= DATA_MAX_X);

  always_comb begin
    if (idle_pending) begin
      sym_kind = SYM_D5_6;  // Input ignored this cycle
    end else if (octet.raw == K28_5_OCTET) begin
      sym_kind = SYM_K28_5;
    end else if (octet.raw == K27_7_OCTET) begin
      sym_kind = SYM_K27_7;
    end else if (octet.raw == K23_7_OCTET) begin
      sym_kind = SYM_K23_7;
    end else if (octet.raw == K29_7_OCTET) begin
      sym_kind = SYM_K29_7;
    end else if (data_ok) begin
      sym_kind = SYM_DATA;
    end else begin
      sym_kind = SYM_NONE;
    end
  end

  // Set for exactly one cycle after K28.5 is taken
  always_ff @(posedge clock) begin
    if (rst) begin
      idle_pending <= 1'b0;
    end else begin
      idle_pending <= (sym_kind == SYM_K28_5);
    end
  end

  // An idle is always the pair K28.5 then D5.6
  idle_pair_a : assert property (
    @(posedge clock) disable iff (rst)
    (sym_kind == SYM_K28_5) |=> (sym_kind == SYM_D5_6)
  );

endmodule

`default_nettype wire

// ==== src/tx_code.sv ====
`timescale 1ns/1ns
`default_nettype none

module tx_code
  import tx_code_pkg::*;
#(
  parameter bit INIT_DISPARITY = 1'b0  // 0 starts in RD-
) (
  input  wire logic               clock,
  input  wire logic               rst,
  input  wire logic [OCTET_W-1:0] tx_o_set,
  output logic      [GROUP_W-1:0] tx_code_group,
  output logic                    tx_even
);

  logic [SYM_W-1:0]   sym_kind;
  logic [3:0]         data_x;
  logic               running_disparity;
  logic [GROUP_W-1:0] next_group;

  ordered_set_decode u_decode (
    .clock    (clock),
    .rst      (rst),
    .tx_o_set (tx_o_set),
    .sym_kind (sym_kind),
    .data_x   (data_x)
  );

  code_group_lookup u_lookup (
    .sym_kind          (sym_kind),
    .data_x            (data_x),
    .running_disparity (running_disparity),
    .tx_code_group     (tx_code_group),  // Held group fed back
    .next_group        (next_group)
  );

  code_group_register #(
    .INIT_DISPARITY (INIT_DISPARITY)
  ) u_register (
    .clock             (clock),
    .rst               (rst),
    .sym_kind          (sym_kind),
    .next_group        (next_group),
    .tx_code_group     (tx_code_group),
    .tx_even           (tx_even),
    .running_disparity (running_disparity)
  );

endmodule

`default_nettype wire

// ==== src/tx_code_pkg.sv ====
`default_nettype none

package tx_code_pkg;

  localparam int OCTET_W = 8;
  localparam int GROUP_W = 10;
  localparam int SYM_W   = 3;

  // Control octets as they arrive on tx_o_set
  localparam logic [OCTET_W-1:0] K28_5_OCTET = 8'hbc;  // Idle comma
  localparam logic [OCTET_W-1:0] K27_7_OCTET = 8'hfb;  // /S/
  localparam logic [OCTET_W-1:0] K23_7_OCTET = 8'hf7;  // /R/
  localparam logic [OCTET_W-1:0] K29_7_OCTET = 8'hfd;  // /T/

  // Data support stops at D9.0
  localparam int unsigned DATA_MAX_X = 9;

  // Symbol kinds handed from the decoder to the lookup
  localparam logic [SYM_W-1:0] SYM_DATA  = 3'd0;
  localparam logic [SYM_W-1:0] SYM_K28_5 = 3'd1;
  localparam logic [SYM_W-1:0] SYM_K27_7 = 3'd2;
  localparam logic [SYM_W-1:0] SYM_K23_7 = 3'd3;
  localparam logic [SYM_W-1:0] SYM_K29_7 = 3'd4;
  localparam logic [SYM_W-1:0] SYM_D5_6  = 3'd5;
  localparam logic [SYM_W-1:0] SYM_NONE  = 3'd7;  // Octet outside the table

  // Control code groups, RD- and RD+ columns
  localparam logic [GROUP_W-1:0] K28_5_NEG = 10'b0011111010;
  localparam logic [GROUP_W-1:0] K28_5_POS = 10'b1100000101;
  localparam logic [GROUP_W-1:0] K27_7_NEG = 10'b1101101000;
  localparam logic [GROUP_W-1:0] K27_7_POS = 10'b0010010111;
  localparam logic [GROUP_W-1:0] K23_7_NEG = 10'b1110101000;
  localparam logic [GROUP_W-1:0] K23_7_POS = 10'b0001010111;
  localparam logic [GROUP_W-1:0] K29_7_NEG = 10'b1011101000;
  localparam logic [GROUP_W-1:0] K29_7_POS = 10'b0100010111;

  localparam logic [GROUP_W-1:0] D5_6_GROUP = 10'b1010010110;  // Balanced

  // D0.0 .. D9.0, indexed by x
  localparam logic [GROUP_W-1:0] DATA_NEG_TABLE [10] = '{
    10'b1001110100,
    10'b0111010100,
    10'b1011010100,
    10'b1100011011,
    10'b1101010100,
    10'b1010011011,
    10'b0110011011,
    10'b1110001011,
    10'b1110010100,
    10'b1001011011
  };

  localparam logic [GROUP_W-1:0] DATA_POS_TABLE [10] = '{
    10'b0110001011,
    10'b1000101011,
    10'b0100101011,
    10'b1100010100,
    10'b0010101011,
    10'b1010010100,
    10'b0110010100,
    10'b0001110100,
    10'b0001101011,
    10'b1001010100
  };

  // Octet seen as a byte or as the y/x fields of Dx.y
  typedef union packed {
    logic [OCTET_W-1:0] raw;
    struct packed {
      logic [2:0] y;
      logic [4:0] x;
    } f;
  } octet_u;

endpackage

`default_nettype wire

// ==== test/tb_tx_code.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tx_code
  import tx_code_pkg::*;
;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DELAY  = 2;  // After the rising edge

  logic               clock;
  logic               rst;
  logic [OCTET_W-1:0] tx_o_set;
  logic [GROUP_W-1:0] tx_code_group;
  logic               tx_even;

  // Stimulus and expected response, one entry per clock
  string              name_q[$];
  logic [OCTET_W-1:0] octet_q[$];
  logic [GROUP_W-1:0] group_q[$];
  logic               even_q[$];

  bit table_loaded;
  int error_count;
  int pass_count;
  int fail_count;

  tx_code #(
    .INIT_DISPARITY (1'b0)
  ) uut (
    .clock         (clock),
    .rst           (rst),
    .tx_o_set      (tx_o_set),
    .tx_code_group (tx_code_group),
    .tx_even       (tx_even)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic add_entry(input string name, input logic [OCTET_W-1:0] octet,
                           input logic [GROUP_W-1:0] group, input logic even);
    name_q.push_back(name);
    octet_q.push_back(octet);
    group_q.push_back(group);
    even_q.push_back(even);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("ok    %s", name);
      pass_count++;
    end else begin
      $display("FAIL  %s", name);
      fail_count++;
    end
  endtask

  // Expected groups follow the 8b/10b column picked by the RD left by the previous group
  task automatic load_table();
    // Data run from RD-
    add_entry("d0_0",             8'h00, 10'b1001110100, 1'b1);  // 5 ones, RD-
    add_entry("d1_0",             8'h01, 10'b0111010100, 1'b0);
    add_entry("d2_0",             8'h02, 10'b1011010100, 1'b1);
    add_entry("d3_0",             8'h03, 10'b1100011011, 1'b0);  // 6 ones, RD+
    add_entry("d4_0",             8'h04, 10'b0010101011, 1'b1);
    add_entry("d5_0",             8'h05, 10'b1010010100, 1'b0);  // 4 ones, RD-
    add_entry("d6_0",             8'h06, 10'b0110011011, 1'b1);  // RD+
    add_entry("d7_0",             8'h07, 10'b0001110100, 1'b0);  // RD-
    add_entry("d8_0",             8'h08, 10'b1110010100, 1'b1);
    add_entry("d9_0",             8'h09, 10'b1001011011, 1'b0);  // RD+
    // Specials from RD+
    add_entry("k27_7_pos",        8'hfb, 10'b0010010111, 1'b1);
    add_entry("k27_7_pos_repeat", 8'hfb, 10'b0010010111, 1'b0);
    add_entry("k23_7_pos",        8'hf7, 10'b0001010111, 1'b1);
    add_entry("k29_7_pos",        8'hfd, 10'b0100010111, 1'b0);
    add_entry("d5_0_to_neg",      8'h05, 10'b1010010100, 1'b1);  // Back to RD-
    // Specials from RD-
    add_entry("k27_7_neg",        8'hfb, 10'b1101101000, 1'b0);
    add_entry("k23_7_neg",        8'hf7, 10'b1110101000, 1'b1);
    add_entry("k29_7_neg",        8'hfd, 10'b1011101000, 1'b0);
    add_entry("k29_7_neg_repeat", 8'hfd, 10'b1011101000, 1'b1);
    // Idle from RD-, the data octet after K28.5 is dropped
    add_entry("k28_5_neg",        8'hbc, 10'b0011111010, 1'b1);  // RD+
    add_entry("d5_6_over_data",   8'h00, 10'b1010010110, 1'b0);
    add_entry("d0_0_pos",         8'h00, 10'b0110001011, 1'b1);
    // Idle from RD+, a special octet is dropped
    add_entry("k28_5_pos",        8'hbc, 10'b1100000101, 1'b1);  // RD-
    add_entry("d5_6_over_k27_7",  8'hfb, 10'b1010010110, 1'b0);
    add_entry("d1_0_after_idle",  8'h01, 10'b0111010100, 1'b1);
    // Unsupported octets hold group and RD
    add_entry("d0_1_unsupported", 8'h20, 10'b0111010100, 1'b0);
    add_entry("d2_0_after_d0_1",  8'h02, 10'b1011010100, 1'b1);  // Still RD-
    add_entry("d3_0_to_pos",      8'h03, 10'b1100011011, 1'b0);  // RD+
    add_entry("d12_0_unsupported", 8'h0c, 10'b1100011011, 1'b1);
    add_entry("d4_0_after_d12_0", 8'h04, 10'b0010101011, 1'b0);  // Still RD+
  endtask

  initial begin
    int errors_before;

    rst          = 1'b1;
    tx_o_set     = '0;
    error_count  = 0;
    pass_count   = 0;
    fail_count   = 0;
    table_loaded = 1'b0;

    load_table();
    table_loaded = 1'b1;

    // Outputs must sit at their reset values while rst is high
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    errors_before = error_count;
    check_value("reset tx_code_group", 32'd0, 32'(tx_code_group));
    check_value("reset tx_even", 32'd0, 32'(tx_even));
    report_test("reset", errors_before);

    rst = 1'b0;
    for (int i = 0; i < name_q.size(); i++) begin
      tx_o_set = octet_q[i];
      @(posedge clock);
      #DRIVE_DELAY;
      errors_before = error_count;
      check_value({name_q[i], " tx_code_group"}, 32'(group_q[i]), 32'(tx_code_group));
      check_value({name_q[i], " tx_even"}, 32'(even_q[i]), 32'(tx_even));
      report_test(name_q[i], errors_before);
    end

    $display("%0d tests run, %0d clean, %0d with mismatches, %0d mismatches in all",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (error_count == 0 && fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Four clocks per table entry plus reset is far more than the run needs
  initial begin
    int limit;

    wait (table_loaded);
    limit = (name_q.size() * 4 + RESET_CYCLES) * CLK_PERIOD;
    #(limit);
    $display("Timeout: the table did not finish within %0d ns", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tx_code.f ====
src/tx_code_pkg.sv
src/ordered_set_decode.sv
src/code_group_lookup.sv
src/code_group_register.sv
src/tx_code.sv
test/tb_tx_code.sv
